/* verification/periph_vectors.txt */
// op addr data expected, hex. op 1 write, 2 read-check, 3 error-check, 4 gpi-drive,
// 5 pwm-window (addr channel, data period*256+duty), 6 irq-check, 7 gpo-random, 8 mtime-advance
2 2008 00000000 ffffffff
2 2004 00000000 00000000
7 0000 00000000 00000000
7 0000 00000000 00000000
2 0008 00000000 00000000
1 0000 00123456 00000000
4 0000 00001a5b 00000000
2 0004 00000000 00001a5b
4 0000 0000ffff 00000000
2 0004 00000000 00001fff
5 0000 00000903 00000003
5 0001 00000400 00000000
5 0002 0000050a 00000006
5 0003 00000f0f 0000000f
5 0000 00000202 00000002
1 1018 12345607 00000000
2 1018 00000000 00000007
2 1020 00000000 00000000
3 3000 deadbeef 00000000
3 3ffc 12345678 00000000
2 0000 00000000 00123456
2 1018 00000000 00000007
1 2004 00000100 00000000
1 2008 00000200 00000000
6 0000 00000000 00000000
2 2004 00000000 00000100
1 2008 00000100 00000000
6 0000 00000000 00000001
1 2008 00000080 00000000
6 0000 00000000 00000001
1 2008 ffffffff 00000000
6 0000 00000000 00000000
1 2000 00000001 00000000
2 2000 00000000 00000001
8 2004 00000005 00000000
2 200c 00000000 00000000
f 0000 00000000 00000000

/* sim.f */
source/periph_pkg.sv
source/apb_decoder.sv
source/gpio_regs.sv
source/pwm_regs.sv
source/pwm_channels.sv
source/machine_timer.sv
source/periph_top.sv
verification/tb_clock_gen.sv
verification/tb_periph_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_periph_top \
  -Mdir obj_dir -o tb_periph_top

output="$(./obj_dir/tb_periph_top 2>&1 || true)"
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* verification/tb_periph_top.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem testbench
// Runs the vector file over the APB port, GPIO pins, PWM and timer outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

  localparam int unsigned GpiWidth     = 13;
  localparam int unsigned GpoWidth     = 24;
  localparam int unsigned PwmWidth     = 4;
  localparam int unsigned PwmCtrSize   = 8;
  localparam int unsigned ChanBits     = $clog2(PwmWidth);
  localparam int unsigned ClkPeriodNs  = 40;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned CyclesPerVec = 300;   // Watchdog budget per vector
  localparam int unsigned MaxVectors   = 64;
  localparam string       VectorFile   = "verification/periph_vectors.txt";
  localparam logic [15:0] LfsrTaps     = 16'hB400;
  localparam logic [15:0] LfsrSeed     = 16'd626;
  localparam logic [15:0] PwmBase      = 16'h1000;

  // Operation codes, first column of the vector file
  localparam logic [31:0] OpWrite       = 32'h1;
  localparam logic [31:0] OpRead        = 32'h2;
  localparam logic [31:0] OpError       = 32'h3;
  localparam logic [31:0] OpGpi         = 32'h4;
  localparam logic [31:0] OpPwm         = 32'h5;
  localparam logic [31:0] OpIrq         = 32'h6;
  localparam logic [31:0] OpGpoRandom   = 32'h7;
  localparam logic [31:0] OpTimeAdvance = 32'h8;
  localparam logic [31:0] OpEnd         = 32'hF;

  logic                  clk_sys;
  logic                  rst_sys_n;
  periph_pkg::apb_addr_t paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  periph_pkg::apb_data_t pwdata;
  periph_pkg::apb_data_t prdata;
  logic                  pready;
  logic                  pslverr;
  logic [GpiWidth-1:0]   gpi;
  logic [GpoWidth-1:0]   gpo;
  logic [PwmWidth-1:0]   pwm;
  logic                  timer_irq;

  logic [31:0]           vec_mem [MaxVectors*4];   // Four words per vector
  int unsigned           vec_count;
  logic                  vectors_ready;
  logic [15:0]           lfsr_state;
  logic [PwmCtrSize-1:0] last_period [PwmWidth];   // Last period set per channel

  tb_clock_gen #(
    .PeriodNs    (ClkPeriodNs),
    .ResetCycles (ResetCycles)
  ) u_clock_gen (
    .clk_o  (clk_sys),
    .rst_no (rst_sys_n)
  );

  periph_top #(
    .GpiWidth   (GpiWidth),
    .GpoWidth   (GpoWidth),
    .PwmWidth   (PwmWidth),
    .PwmCtrSize (PwmCtrSize)
  ) i_dut (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .gpi_i       (gpi),
    .gpo_o       (gpo),
    .pwm_o       (pwm),
    .timer_irq_o (timer_irq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ LfsrTaps;
    return next;
  endfunction

  // One step per bit, LSB first
  task automatic draw_random_word(output periph_pkg::apb_data_t word);
    for (int b = 0; b < periph_pkg::ApbDataWidth; b++) begin
      word[b]    = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input periph_pkg::apb_data_t expected,
                            input periph_pkg::apb_data_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s pslverr expected %b actual %b",
                              name, expected, actual));
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // Setup and access phase, then one idle cycle
  task automatic apb_transfer(input string name, input logic write,
                              input periph_pkg::apb_addr_t addr,
                              input periph_pkg::apb_data_t wdata,
                              output periph_pkg::apb_data_t rdata, output logic err);
    @(negedge clk_sys);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_sys);
    penable = 1'b1;
    #(ClkPeriodNs / 4);   // Mid access phase
    check_level({name, " pready"}, 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk_sys);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Configures one channel and counts its high cycles over one period
  task automatic run_pwm_window(input string name, input periph_pkg::apb_addr_t chan_field,
                                input periph_pkg::apb_data_t cfg,
                                input periph_pkg::apb_data_t expected);
    logic [ChanBits-1:0]   chan;
    logic [PwmCtrSize-1:0] duty;
    logic [PwmCtrSize-1:0] period;
    periph_pkg::apb_addr_t duty_addr;
    periph_pkg::apb_data_t rdata;
    logic                  err;
    int unsigned           high_cnt;
    chan      = chan_field[ChanBits-1:0];
    duty      = cfg[PwmCtrSize-1:0];
    period    = cfg[2*PwmCtrSize-1:PwmCtrSize];
    duty_addr = PwmBase | (16'(chan) << 3);
    apb_transfer(name, 1'b1, duty_addr, 32'(duty), rdata, err);
    apb_transfer(name, 1'b1, duty_addr | 16'h4, 32'(period), rdata, err);
    apb_transfer(name, 1'b0, duty_addr, '0, rdata, err);
    check_data({name, " duty readback"}, 32'(duty), rdata);
    apb_transfer(name, 1'b0, duty_addr | 16'h4, '0, rdata, err);
    check_data({name, " period readback"}, 32'(period), rdata);
    // The running pass may still reach the old period
    repeat (32'(last_period[chan]) + 32'(period) + 4) @(negedge clk_sys);
    last_period[chan] = period;
    high_cnt = 0;
    repeat (32'(period) + 1) begin
      @(negedge clk_sys);
      if (pwm[chan]) high_cnt++;
    end
    check_data({name, " high cycles"}, expected, high_cnt);
  endtask

  task automatic run_vector(input int unsigned idx);
    logic [31:0]           op;
    periph_pkg::apb_addr_t addr;
    periph_pkg::apb_data_t data;
    periph_pkg::apb_data_t expected;
    periph_pkg::apb_data_t rdata;
    periph_pkg::apb_data_t first;
    logic                  err;
    string                 name;
    op       = vec_mem[4*idx];
    addr     = vec_mem[4*idx+1][15:0];
    data     = vec_mem[4*idx+2];
    expected = vec_mem[4*idx+3];
    name     = $sformatf("vector %0d (op %0h, addr %h)", idx + 1, op, addr);
    case (op)
      OpWrite: begin
        apb_transfer(name, 1'b1, addr, data, rdata, err);
        check_resp(name, 1'b0, err);
      end
      OpRead: begin
        apb_transfer(name, 1'b0, addr, '0, rdata, err);
        check_resp(name, 1'b0, err);
        check_data(name, expected, rdata);
      end
      OpError: begin   // Write then read, both rejected
        apb_transfer(name, 1'b1, addr, data, rdata, err);
        check_resp({name, " write"}, 1'b1, err);
        apb_transfer(name, 1'b0, addr, '0, rdata, err);
        check_resp({name, " read"}, 1'b1, err);
        check_data({name, " read data"}, '0, rdata);
      end
      OpGpi: begin
        @(negedge clk_sys);
        gpi = data[GpiWidth-1:0];
        repeat (3) @(negedge clk_sys);   // Through both sync stages
      end
      OpPwm: run_pwm_window(name, addr, data, expected);
      OpIrq: begin
        repeat (2) @(negedge clk_sys);
        check_level({name, " timer_irq_o"}, expected[0], timer_irq);
      end
      OpGpoRandom: begin
        draw_random_word(first);
        apb_transfer(name, 1'b1, addr, first, rdata, err);
        check_resp(name, 1'b0, err);
        check_data({name, " gpo_o"}, 32'(first[GpoWidth-1:0]), 32'(gpo));
        apb_transfer(name, 1'b0, addr, '0, rdata, err);
        check_data({name, " readback"}, 32'(first[GpoWidth-1:0]), rdata);
      end
      OpTimeAdvance: begin
        apb_transfer(name, 1'b0, addr, '0, first, err);
        repeat (data) @(negedge clk_sys);
        apb_transfer(name, 1'b0, addr, '0, rdata, err);
        check_level({name, " mtime advanced"}, 1'b1, rdata > first);
      end
      default: stop_on_error($sformatf("%s has an unknown operation code", name));
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    vectors_ready = 1'b0;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    gpi           = '0;
    lfsr_state    = LfsrSeed;
    for (int c = 0; c < PwmWidth; c++) last_period[c] = '0;
    $readmemh(VectorFile, vec_mem);
    vec_count = 0;
    while (vec_count < MaxVectors && vec_mem[4*vec_count] != OpEnd) vec_count++;
    if (vec_count == MaxVectors) stop_on_error("vector file has no end marker");
    vectors_ready = 1'b1;
    wait (rst_sys_n === 1'b1);
    @(negedge clk_sys);
    check_data("reset gpo_o", '0, 32'(gpo));
    check_data("reset pwm_o", '0, 32'(pwm));
    check_level("reset timer_irq_o", 1'b0, timer_irq);
    check_level("reset pready_o", 1'b0, pready);
    check_resp("reset", 1'b0, pslverr);
    for (int unsigned i = 0; i < vec_count; i++) run_vector(i);
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    longint unsigned limit_ns;
    wait (vectors_ready === 1'b1);
    limit_ns = 64'(vec_count + ResetCycles) * CyclesPerVec * ClkPeriodNs;
    #(limit_ns);
    $display("timeout: the vectors did not finish within %0d ns", limit_ns);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock and an active-low reset held for a set number of cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* source/periph_top.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem top level
// APB port to GPIO, PWM and machine timer through the region decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module periph_top #(
  parameter int unsigned GpiWidth   = 13,
  parameter int unsigned GpoWidth   = 24,
  parameter int unsigned PwmWidth   = 4,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  // APB host port
  input  periph_pkg::apb_addr_t paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,

  // Pins
  input  logic [GpiWidth-1:0]   gpi_i,
  output logic [GpoWidth-1:0]   gpo_o,
  output logic [PwmWidth-1:0]   pwm_o,
  output logic                  timer_irq_o
);

  logic                  gpio_sel;
  logic                  pwm_sel;
  logic                  timer_sel;
  periph_pkg::apb_data_t gpio_rdata;
  periph_pkg::apb_data_t pwm_rdata;
  periph_pkg::apb_data_t timer_rdata;
  logic [PwmCtrSize-1:0] pwm_duty   [PwmWidth];  // Register block to counters
  logic [PwmCtrSize-1:0] pwm_period [PwmWidth];

  apb_decoder u_apb_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .gpio_rdata_i  (gpio_rdata),
    .pwm_rdata_i   (pwm_rdata),
    .timer_rdata_i (timer_rdata),
    .gpio_sel_o    (gpio_sel),
    .pwm_sel_o     (pwm_sel),
    .timer_sel_o   (timer_sel),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o)
  );

  gpio_regs #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth )
  ) u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .sel_i      (gpio_sel),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .gpi_i      (gpi_i),
    .prdata_o   (gpio_rdata),
    .gpo_o      (gpo_o)
  );

  pwm_regs #(
    .PwmWidth   ( PwmWidth   ),
    .PwmCtrSize ( PwmCtrSize )
  ) u_pwm_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .sel_i      (pwm_sel),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (pwm_rdata),
    .duty_o     (pwm_duty),
    .period_o   (pwm_period)
  );

  pwm_channels #(
    .PwmWidth   ( PwmWidth   ),
    .PwmCtrSize ( PwmCtrSize )
  ) u_pwm_channels (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .duty_i     (pwm_duty),
    .period_i   (pwm_period),
    .pwm_o      (pwm_o)
  );

  machine_timer u_machine_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .sel_i       (timer_sel),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

/* source/machine_timer.sv */
////////////////////////////////////////////////////////////////////////////
// Machine timer
// mtime counter with mtimecmp compare and a registered interrupt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module machine_timer (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic                  sel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  timer_irq_o
);

  localparam logic [periph_pkg::RegOfsWidth-1:0] CtrlWord =
      periph_pkg::TimerCtrlOfs[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  localparam logic [periph_pkg::RegOfsWidth-1:0] TimeWord =
      periph_pkg::TimerTimeOfs[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  localparam logic [periph_pkg::RegOfsWidth-1:0] CmpWord =
      periph_pkg::TimerCmpOfs[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];

  logic [periph_pkg::RegOfsWidth-1:0] word_ofs;
  logic                               wr_en;
  logic                               enable_q;    // Ctrl bit 0
  periph_pkg::apb_data_t              mtime_q;
  periph_pkg::apb_data_t              mtimecmp_q;
  logic                               cmp_hit;
  logic                               irq_q;

  assign word_ofs = paddr_i[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  assign wr_en    = sel_i & penable_i & pwrite_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      enable_q   <= 1'b0;
      mtimecmp_q <= '1;     // Far future, no interrupt out of reset
    end else if (wr_en) begin
      if (word_ofs == CtrlWord) enable_q   <= pwdata_i[0];
      if (word_ofs == CmpWord)  mtimecmp_q <= pwdata_i;
    end
  end

  // A host write wins over the increment
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (wr_en && (word_ofs == TimeWord)) begin
      mtime_q <= pwdata_i;
    end else if (enable_q) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Compare runs even while counting is stopped
  assign cmp_hit = (mtime_q >= mtimecmp_q);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= cmp_hit;
    end
  end

  assign timer_irq_o = irq_q;

  always_comb begin
    prdata_o = '0;
    if (word_ofs == CtrlWord) prdata_o = periph_pkg::apb_data_t'(enable_q);
    if (word_ofs == TimeWord) prdata_o = mtime_q;
    if (word_ofs == CmpWord)  prdata_o = mtimecmp_q;
  end

endmodule

`default_nettype wire

/* source/pwm_channels.sv */
////////////////////////////////////////////////////////////////////////////
// PWM channel counters
// One wrapping counter and registered output per channel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pwm_channels #(
  parameter int unsigned PwmWidth   = 4,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic [PwmCtrSize-1:0] duty_i   [PwmWidth],
  input  logic [PwmCtrSize-1:0] period_i [PwmWidth],
  output logic [PwmWidth-1:0]   pwm_o
);

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    logic [PwmCtrSize-1:0] ctr_q;
    logic                  pwm_q;

    // Counts 0 to period inclusive
    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        ctr_q <= '0;
      end else if (ctr_q >= period_i[i]) begin  // Also catches a shrunk period
        ctr_q <= '0;
      end else begin
        ctr_q <= ctr_q + 1'b1;
      end
    end

    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        pwm_q <= 1'b0;
      end else begin
        pwm_q <= (ctr_q < duty_i[i]);
      end
    end

    assign pwm_o[i] = pwm_q;

    // A count above the period only right after the period was lowered
    ctr_in_period_a : assert property (
      @(posedge clk_sys_i) disable iff (!rst_sys_ni)
      (ctr_q > period_i[i]) |-> (period_i[i] != $past(period_i[i]))
    );
  end

endmodule

`default_nettype wire

/* source/pwm_regs.sv */
////////////////////////////////////////////////////////////////////////////
// PWM configuration registers
// Duty and period per channel, written and read back over APB
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pwm_regs #(
  parameter int unsigned PwmWidth   = 4,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic                  sel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic [PwmCtrSize-1:0] duty_o   [PwmWidth],
  output logic [PwmCtrSize-1:0] period_o [PwmWidth]
);

  localparam int unsigned ChanIdxW = periph_pkg::RegOfsWidth - 1;  // Word offset over two

  logic [periph_pkg::RegOfsWidth-1:0] word_ofs;
  logic [ChanIdxW-1:0]                chan_idx;
  logic [PwmWidth-1:0]                chan_hit;
  logic                               is_duty;
  logic                               is_period;
  logic                               wr_en;

  assign word_ofs  = paddr_i[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  assign chan_idx  = word_ofs[periph_pkg::RegOfsWidth-1:1];
  assign is_duty   = (word_ofs[0] == periph_pkg::PwmDutyOfs[periph_pkg::RegOfsLsb]);
  assign is_period = (word_ofs[0] == periph_pkg::PwmPeriodOfs[periph_pkg::RegOfsLsb]);
  assign wr_en     = sel_i & penable_i & pwrite_i;

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    localparam logic [ChanIdxW-1:0] ChanIdx = ChanIdxW'(i);

    logic [PwmCtrSize-1:0] duty_q;
    logic [PwmCtrSize-1:0] period_q;

    assign chan_hit[i] = (chan_idx == ChanIdx);

    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        duty_q   <= '0;
        period_q <= '0;
      end else if (wr_en && chan_hit[i]) begin
        if (is_duty)   duty_q   <= pwdata_i[PwmCtrSize-1:0];  // Upper bits dropped
        if (is_period) period_q <= pwdata_i[PwmCtrSize-1:0];
      end
    end

    assign duty_o[i]   = duty_q;
    assign period_o[i] = period_q;
  end

  // Offsets past the last channel read zero
  always_comb begin
    prdata_o = '0;
    for (int i = 0; i < PwmWidth; i++) begin
      if (chan_hit[i] && is_duty)   prdata_o = periph_pkg::apb_data_t'(duty_o[i]);
      if (chan_hit[i] && is_period) prdata_o = periph_pkg::apb_data_t'(period_o[i]);
    end
  end

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
////////////////////////////////////////////////////////////////////////////
// GPIO registers
// Output register and synchronized inputs, both readable over APB
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic                  sel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  input  logic [GpiWidth-1:0]   gpi_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic [GpoWidth-1:0]   gpo_o
);

  localparam logic [periph_pkg::RegOfsWidth-1:0] OutWord =
      periph_pkg::GpioOutOfs[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  localparam logic [periph_pkg::RegOfsWidth-1:0] InWord =
      periph_pkg::GpioInOfs[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];

  logic [periph_pkg::RegOfsWidth-1:0] word_ofs;
  logic                               wr_en;
  logic [GpoWidth-1:0]                gpo_q;
  logic [GpiWidth-1:0]                gpi_meta_q;  // First sync stage
  logic [GpiWidth-1:0]                gpi_sync_q;

  assign word_ofs = paddr_i[periph_pkg::RegionLsb-1:periph_pkg::RegOfsLsb];
  assign wr_en    = sel_i & penable_i & pwrite_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q <= '0;
    end else if (wr_en && (word_ofs == OutWord)) begin
      gpo_q <= pwdata_i[GpoWidth-1:0];
    end
  end

  // Two flops against metastability on the pins
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gpi_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (word_ofs == OutWord) prdata_o = periph_pkg::apb_data_t'(gpo_q);
    if (word_ofs == InWord)  prdata_o = periph_pkg::apb_data_t'(gpi_sync_q);
  end

  assign gpo_o = gpo_q;

endmodule

`default_nettype wire

/* source/apb_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// APB region decoder
// Routes the host select to one peripheral and merges the responses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  periph_pkg::apb_addr_t paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  periph_pkg::apb_data_t gpio_rdata_i,
  input  periph_pkg::apb_data_t pwm_rdata_i,
  input  periph_pkg::apb_data_t timer_rdata_i,
  output logic                  gpio_sel_o,
  output logic                  pwm_sel_o,
  output logic                  timer_sel_o,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  periph_pkg::region_e region;
  logic                access;   // Second cycle of a transfer

  assign region = periph_pkg::region_e'(paddr_i[periph_pkg::RegionMsb:periph_pkg::RegionLsb]);
  assign access = psel_i & penable_i;

  // One select per peripheral
  assign gpio_sel_o  = psel_i & (region == periph_pkg::RegionGpio);
  assign pwm_sel_o   = psel_i & (region == periph_pkg::RegionPwm);
  assign timer_sel_o = psel_i & (region == periph_pkg::RegionTimer);

  // No wait states
  assign pready_o  = access;
  assign pslverr_o = access & (region == periph_pkg::RegionNone);

  always_comb begin
    unique case (region)
      periph_pkg::RegionGpio:  prdata_o = gpio_rdata_i;
      periph_pkg::RegionPwm:   prdata_o = pwm_rdata_i;
      periph_pkg::RegionTimer: prdata_o = timer_rdata_i;
      default:                 prdata_o = '0;  // Unmapped reads zero
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Access phase only after a setup phase of the same transfer
  enable_after_setup_a : assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $rose(penable_i) |-> (psel_i && $past(psel_i))
  );

endmodule

`default_nettype wire

/* source/periph_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem definitions
// APB widths, region map and register offsets shared by the blocks
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package periph_pkg;

  // APB bus widths
  localparam int unsigned ApbAddrWidth = 16;
  localparam int unsigned ApbDataWidth = 32;

  typedef logic [ApbAddrWidth-1:0] apb_addr_t;  // Byte address
  typedef logic [ApbDataWidth-1:0] apb_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  // One 4 KiB region per peripheral
  typedef enum logic [1:0] {
    RegionGpio  = 2'd0,
    RegionPwm   = 2'd1,
    RegionTimer = 2'd2,
    RegionNone  = 2'd3   // Unmapped, answers with an error
  } region_e;

  localparam int unsigned RegionMsb   = 13;
  localparam int unsigned RegionLsb   = 12;
  localparam int unsigned RegOfsLsb   = 2;                       // Word registers
  localparam int unsigned RegOfsWidth = RegionLsb - RegOfsLsb;   // Word offset bits

  // GPIO registers
  localparam apb_addr_t GpioOutOfs = 16'h0000;  // Read/write
  localparam apb_addr_t GpioInOfs  = 16'h0004;  // Read only

  // PWM registers, channel n adds 8 times n
  localparam apb_addr_t PwmDutyOfs   = 16'h0000;
  localparam apb_addr_t PwmPeriodOfs = 16'h0004;

  // Timer registers
  localparam apb_addr_t TimerCtrlOfs = 16'h0000;  // Bit 0 enables counting
  localparam apb_addr_t TimerTimeOfs = 16'h0004;  // mtime
  localparam apb_addr_t TimerCmpOfs  = 16'h0008;  // mtimecmp

endpackage

`default_nettype wire
